/* include/icache_config.svh */
// cache geometry and bus constants, included by the cache packages and RTL modules
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// ==============================
// address and data widths
// ==============================
`define ICACHE_ADDR_W       32
`define ICACHE_INST_W       32
`define ICACHE_BEAT_W       64

// ==============================
// cache geometry
// ==============================
// 2 ways x 256 sets x 8 byte blocks
`define ICACHE_SETS         256
`define ICACHE_INDEX_W      8
`define ICACHE_OFFSET_W     3
`define ICACHE_TAG_W        21

// addi x0, x0, 0
`define ICACHE_NOP          32'h0000_0013

`define ICACHE_RESP_OKAY    2'b00

`endif

/* verilog/icache_pkg.sv */
// address-field, instruction and storage types shared by the instruction cache modules
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]    addr_t;
    typedef logic [`ICACHE_TAG_W-1:0]     tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]   index_t;
    typedef logic [`ICACHE_INST_W-1:0]    inst_t;
    typedef logic [`ICACHE_BEAT_W-1:0]    beat_t;
    // way 1 in the upper half
    typedef logic [2*`ICACHE_BEAT_W-1:0]  row_t;
    typedef logic                         way_t;

    // ==============================
    // address fields
    // ==============================
    function automatic tag_t addr_tag(addr_t addr);
        return addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    endfunction

endpackage

/* verilog/fetch_pkg.sv */
// miss controller state and read response types for the fetch side of the cache

package fetch_pkg;

    // ==============================
    // miss handling FSM
    // ==============================
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WAIT
    } fetch_state_t;

    // read response code with OKAY as 2'b00
    typedef logic [1:0] resp_t;

endpackage

/* verilog/icache_fill_if.sv */
// refill write port, driven by the miss controller and read by the tag and data arrays
`timescale 1ns/10ps

interface icache_fill_if import icache_pkg::*; ();

    // one-cycle write strobe
    logic    fill_en;
    index_t  fill_index;
    tag_t    fill_tag;
    way_t    fill_way;
    beat_t   fill_data;

    modport ctrl (
        output fill_en,
        output fill_index,
        output fill_tag,
        output fill_way,
        output fill_data
    );

    modport array (
        input  fill_en,
        input  fill_index,
        input  fill_tag,
        input  fill_way,
        input  fill_data
    );

endinterface

/* verilog/icache_tag_array.sv */
// tag store of the two-way cache; combinational hit check and victim choice for pc
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_tag_array import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  addr_t              pc,
    input  logic               alloc,
    icache_fill_if.array       fill,
    output logic               hit,
    output way_t               hit_way,
    output way_t               victim_way
);

    tag_t                      tag_mem [2][`ICACHE_SETS];
    logic [1:0]                valid_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   victim_bits;

    index_t                    pc_index;
    tag_t                      pc_tag;
    logic                      way0_hit;
    logic                      way1_hit;

    assign pc_index = addr_index(pc);
    assign pc_tag   = addr_tag(pc);

    // ==============================
    // lookup
    // ==============================
    assign way0_hit = valid_mem[pc_index][0] && (tag_mem[0][pc_index] == pc_tag);
    assign way1_hit = valid_mem[pc_index][1] && (tag_mem[1][pc_index] == pc_tag);

    assign hit     = way0_hit | way1_hit;
    // way 0 wins
    assign hit_way = ~way0_hit;

    // empty way first, otherwise flip the set's bit
    always_comb begin
        if (!valid_mem[pc_index][0]) begin
            victim_way = 1'b0;
        end else if (!valid_mem[pc_index][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ~victim_bits[pc_index];
        end
    end

    // ==============================
    // updates
    // ==============================
    always_ff @(posedge clk) begin
        if (fill.fill_en) begin
            tag_mem[fill.fill_way][fill.fill_index] <= fill.fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                valid_mem[i] <= 2'b00;
            end
        end else if (fill.fill_en) begin
            valid_mem[fill.fill_index][fill.fill_way] <= 1'b1;
        end
    end

    // victim bit moves when the miss starts, not at refill
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_bits <= '0;
        end else if (alloc) begin
            victim_bits[pc_index] <= victim_way;
        end
    end

endmodule

/* verilog/icache_data_ram.sv */
// block storage of the two-way cache with way-masked refill and registered word read
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_data_ram import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  addr_t              pc,
    input  logic               lookup,
    input  way_t               way,
    icache_fill_if.array       fill,
    output inst_t              word
);

    row_t    row_mem [`ICACHE_SETS];

    row_t    rd_row;
    way_t    rd_way;
    logic    rd_hi;
    beat_t   rd_block;

    // ==============================
    // refill of the victim half only
    // ==============================
    always_ff @(posedge clk) begin
        if (fill.fill_en) begin
            if (fill.fill_way) begin
                row_mem[fill.fill_index][2*`ICACHE_BEAT_W-1 -: `ICACHE_BEAT_W] <= fill.fill_data;
            end else begin
                row_mem[fill.fill_index][`ICACHE_BEAT_W-1:0] <= fill.fill_data;
            end
        end
    end

    // ==============================
    // read
    // ==============================
    always_ff @(posedge clk) begin
        if (lookup) begin
            rd_row <= row_mem[addr_index(pc)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_way <= 1'b0;
            rd_hi  <= 1'b0;
        end else if (lookup) begin
            rd_way <= way;
            rd_hi  <= pc[`ICACHE_OFFSET_W-1];
        end
    end

    assign rd_block = rd_way ? rd_row[2*`ICACHE_BEAT_W-1 -: `ICACHE_BEAT_W]
                             : rd_row[`ICACHE_BEAT_W-1:0];

    // upper word when pc bit 2 was set
    assign word = rd_hi ? rd_block[`ICACHE_BEAT_W-1 -: `ICACHE_INST_W]
                        : rd_block[`ICACHE_INST_W-1:0];

endmodule

/* verilog/icache_miss_ctrl.sv */
// fetch FSM of the cache: hit buffering, single-beat bus read on a miss and refill strobe
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_miss_ctrl
    import icache_pkg::*;
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  addr_t              pc,
    input  logic               stall,
    input  logic               flush,
    input  logic               hit,
    input  way_t               victim_way,
    input  inst_t              cache_word,
    output logic               alloc,
    output logic               lookup,
    icache_fill_if.ctrl        fill,
    input  logic               arready,
    output logic               arvalid,
    output addr_t              araddr,
    input  logic               rvalid,
    output logic               rready,
    input  beat_t              rdata,
    input  resp_t              rresp,
    output inst_t              inst,
    output logic               inst_valid,
    output logic               error
);

    fetch_state_t   state;
    fetch_state_t   state_next;

    logic           flush_taken;
    logic           beat_done;
    logic           resp_ok;
    way_t           fill_way_q;
    logic           word_hi;
    logic           hit_buf;
    inst_t          bus_inst;

    assign flush_taken = flush & ~stall;

    assign lookup = (state == FETCH_IDLE) & hit;
    // a flushed fetch never starts a miss
    assign alloc  = (state == FETCH_IDLE) & ~hit & ~stall & ~flush;

    assign rready    = (state == FETCH_WAIT);
    assign beat_done = rready & rvalid;
    assign resp_ok   = (rresp == `ICACHE_RESP_OKAY);

    // ==============================
    // state machine
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            FETCH_IDLE: begin
                if (alloc) begin
                    state_next = FETCH_REQUEST;
                end
            end
            FETCH_REQUEST: begin
                if (arvalid & arready) begin
                    state_next = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (rvalid) begin
                    state_next = FETCH_IDLE;
                end
            end
            default: begin
                state_next = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_taken) begin
            state <= FETCH_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ==============================
    // bus request
    // ==============================
    always_ff @(posedge clk) begin
        if (rst || flush_taken) begin
            arvalid <= 1'b0;
        end else if (alloc) begin
            arvalid <= 1'b1;
        end else if (arvalid & arready) begin
            arvalid <= 1'b0;
        end
    end

    // block address, way and word select held for the whole miss
    always_ff @(posedge clk) begin
        if (alloc) begin
            araddr     <= {pc[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
            fill_way_q <= victim_way;
            word_hi    <= pc[`ICACHE_OFFSET_W-1];
        end
    end

    // ==============================
    // refill
    // ==============================
    // bad beats are dropped so the block misses again
    assign fill.fill_en    = beat_done & resp_ok;
    assign fill.fill_index = addr_index(araddr);
    assign fill.fill_tag   = addr_tag(araddr);
    assign fill.fill_way   = fill_way_q;
    assign fill.fill_data  = rdata;

    // ==============================
    // output side
    // ==============================
    always_ff @(posedge clk) begin
        if (rst || flush_taken) begin
            bus_inst <= `ICACHE_NOP;
        end else if (beat_done) begin
            bus_inst <= word_hi ? rdata[`ICACHE_BEAT_W-1 -: `ICACHE_INST_W]
                                : rdata[`ICACHE_INST_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_taken) begin
            hit_buf <= 1'b0;
        end else if (lookup) begin
            hit_buf <= 1'b1;
        end else if (alloc) begin
            hit_buf <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_taken) begin
            inst_valid <= 1'b1;
        end else if (alloc) begin
            inst_valid <= 1'b0;
        end else if (beat_done) begin
            inst_valid <= 1'b1;
        end
    end

    // sticky until the next beat comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (beat_done) begin
            error <= ~resp_ok;
        end
    end

    assign inst = hit_buf ? cache_word : bus_inst;

endmodule

/* verilog/ifu_icache.sv */
// instruction cache top level for the fetch stage, with a single-beat read bus port
`timescale 1ns/10ps
`include "icache_config.svh"

module ifu_icache
    import icache_pkg::*;
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  addr_t   pc,
    input  logic    flush,
    input  logic    stall,
    // read bus
    input  logic    arready,
    output logic    arvalid,
    output addr_t   araddr,
    input  logic    rvalid,
    output logic    rready,
    input  beat_t   rdata,
    input  resp_t   rresp,
    // to decode
    output inst_t   inst,
    output logic    inst_valid,
    output logic    error
);

    logic    hit;
    way_t    hit_way;
    way_t    victim_way;
    logic    alloc;
    logic    lookup;
    inst_t   cache_word;

    icache_fill_if fill_bus ();

    icache_tag_array u_tag_array (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .alloc      (alloc),
        .fill       (fill_bus.array),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_ram u_data_ram (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .lookup (lookup),
        .way    (hit_way),
        .fill   (fill_bus.array),
        .word   (cache_word)
    );

    icache_miss_ctrl u_miss_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .hit        (hit),
        .victim_way (victim_way),
        .cache_word (cache_word),
        .alloc      (alloc),
        .lookup     (lookup),
        .fill       (fill_bus.ctrl),
        .arready    (arready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error)
    );

endmodule

/* test/tb_clock_gen.sv */
// testbench clock of 100 ns period and a synchronous reset held for 8 cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic    clk,
    output logic    rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release on a falling edge like every other input
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* test/tb_ifu_icache.sv */
// table-driven testbench of the instruction cache, with a read bus memory and a reference cache
`timescale 1ns/10ps
`include "icache_config.svh"

module tb_ifu_icache
    import icache_pkg::*;
    import fetch_pkg::*;
();

    typedef enum logic [1:0] {KIND_FETCH, KIND_STALL, KIND_FLUSH, KIND_ERROR} entry_kind_t;

    typedef struct {
        addr_t        pc;
        entry_kind_t  kind;
        logic         exp_hit;
    } entry_t;

    localparam int    NUM_ENTRIES    = 22;
    localparam int    TIMEOUT_CYCLES = NUM_ENTRIES * 12;
    localparam resp_t RESP_BAD       = 2'b10;

    logic    clk;
    logic    rst;
    addr_t   pc;
    logic    flush;
    logic    stall;
    logic    arready;
    logic    arvalid;
    addr_t   araddr;
    logic    rvalid;
    logic    rready;
    beat_t   rdata;
    resp_t   rresp;
    inst_t   inst;
    logic    inst_valid;
    logic    error;

    entry_t       entries [NUM_ENTRIES];
    logic         ref_valid [`ICACHE_SETS][2];
    tag_t         ref_tag [`ICACHE_SETS][2];
    way_t         ref_victim [`ICACHE_SETS];
    logic         exp_error;
    logic [31:0]  lfsr;
    int           checks     = 0;
    int           mismatches = 0;
    int           failures   = 0;
    int           cycles     = 0;

    tb_clock_gen clock0 (.clk(clk), .rst(rst));

    ifu_icache dut0 (
        .clk(clk), .rst(rst), .pc(pc), .flush(flush), .stall(stall),
        .arready(arready), .arvalid(arvalid), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .inst(inst), .inst_valid(inst_valid), .error(error)
    );

    // ==============================
    // stimulus table
    // ==============================
    task automatic load_entries();
        entries[0]  = '{32'h0000_0100, KIND_FETCH, 1'b0};
        entries[1]  = '{32'h0000_0104, KIND_FETCH, 1'b1};
        entries[2]  = '{32'h0000_020c, KIND_FETCH, 1'b0};
        entries[3]  = '{32'h0000_0208, KIND_FETCH, 1'b1};
        entries[4]  = '{32'h0000_0100, KIND_FETCH, 1'b1};
        // three blocks in set 0x10
        entries[5]  = '{32'h0000_0080, KIND_FETCH, 1'b0};
        entries[6]  = '{32'h0000_0884, KIND_FETCH, 1'b0};
        entries[7]  = '{32'h0000_1080, KIND_FETCH, 1'b0};
        entries[8]  = '{32'h0000_0880, KIND_FETCH, 1'b1};
        entries[9]  = '{32'h0000_0084, KIND_FETCH, 1'b0};
        entries[10] = '{32'h0000_1084, KIND_FETCH, 1'b1};
        entries[11] = '{32'h0000_0880, KIND_FETCH, 1'b0};
        entries[12] = '{32'h0000_0300, KIND_STALL, 1'b0};
        entries[13] = '{32'h0000_0304, KIND_FETCH, 1'b1};
        entries[14] = '{32'h0000_0300, KIND_FLUSH, 1'b0};
        entries[15] = '{32'h0000_0300, KIND_FETCH, 1'b1};
        entries[16] = '{32'h0000_0400, KIND_FLUSH, 1'b0};
        entries[17] = '{32'h0000_0404, KIND_FETCH, 1'b0};
        entries[18] = '{32'h0000_0500, KIND_ERROR, 1'b0};
        entries[19] = '{32'h0000_0104, KIND_FETCH, 1'b1};
        entries[20] = '{32'h0000_0504, KIND_FETCH, 1'b0};
        entries[21] = '{32'h0000_0500, KIND_FETCH, 1'b1};
    endtask

    // ==============================
    // random delays and memory contents
    // ==============================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr  = lfsr_next(lfsr);
            value = value * 2 + int'(lfsr[0]);
        end
        return value;
    endfunction

    // the two words of a block differ, and every block differs
    function automatic beat_t mem_beat(input addr_t a);
        addr_t blk;
        blk = {a[31:3], 3'b000};
        return {blk ^ 32'h5a5a_0004, blk ^ 32'h0000_c3c3};
    endfunction

    function automatic inst_t expected_word(input addr_t a);
        beat_t b;
        b = mem_beat(a);
        return a[2] ? b[63:32] : b[31:0];
    endfunction

    // ==============================
    // reference cache
    // ==============================
    task automatic clear_model();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
            ref_victim[s]   = 1'b0;
        end
    endtask

    function automatic logic model_hit(input addr_t a);
        index_t idx;
        tag_t   t;
        idx = a[10:3];
        t   = a[31:11];
        return (ref_valid[idx][0] && ref_tag[idx][0] == t) ||
               (ref_valid[idx][1] && ref_tag[idx][1] == t);
    endfunction

    // empty way first, else the victim bit toggles; bad beats leave the line empty
    function automatic void model_allocate(input addr_t a, input logic ok);
        index_t idx;
        way_t   way;
        idx = a[10:3];
        if (!ref_valid[idx][0]) begin
            way = 1'b0;
        end else if (!ref_valid[idx][1]) begin
            way = 1'b1;
        end else begin
            way = ~ref_victim[idx];
        end
        ref_victim[idx] = way;
        if (ok) begin
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = a[31:11];
        end
    endfunction

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ==============================
    // bus memory and entry handling
    // ==============================
    task automatic serve_read(input addr_t fetch_pc, input resp_t resp);
        addr_t blk;
        int    delay;
        blk = {fetch_pc[31:3], 3'b000};
        check_addr(araddr, blk, "araddr");
        delay = take_bits(2);
        repeat (delay) begin
            @(negedge clk);
            check_flag(arvalid, 1'b1, "arvalid held");
            check_addr(araddr, blk, "araddr held");
            check_flag(inst_valid, 1'b0, "inst_valid in address wait");
        end
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        check_flag(arvalid, 1'b0, "arvalid after accept");
        check_flag(rready, 1'b1, "rready after accept");
        delay = take_bits(2);
        repeat (delay) begin
            @(negedge clk);
            check_flag(arvalid, 1'b0, "arvalid in data wait");
            check_flag(rready, 1'b1, "rready in data wait");
            check_flag(inst_valid, 1'b0, "inst_valid in data wait");
        end
        rvalid = 1'b1;
        rdata  = mem_beat(blk);
        rresp  = resp;
        @(negedge clk);
        rvalid = 1'b0;
        rresp  = `ICACHE_RESP_OKAY;
        check_flag(rready, 1'b0, "rready after beat");
        check_flag(arvalid, 1'b0, "arvalid after beat");
    endtask

    task automatic do_fetch(input addr_t fetch_pc, input logic pred_hit, input resp_t resp);
        pc    = fetch_pc;
        stall = 1'b0;
        flush = 1'b0;
        @(negedge clk);
        check_flag(arvalid, ~pred_hit, "arvalid after lookup");
        check_flag(inst_valid, pred_hit, "inst_valid after lookup");
        if (!pred_hit) begin
            serve_read(fetch_pc, resp);
            model_allocate(fetch_pc, resp == `ICACHE_RESP_OKAY);
            exp_error = (resp != `ICACHE_RESP_OKAY);
        end
        check_flag(inst_valid, 1'b1, "inst_valid");
        check_inst(inst, expected_word(fetch_pc), "inst");
        check_flag(error, exp_error, "error");
    endtask

    task automatic hold_stall(input addr_t fetch_pc);
        pc    = fetch_pc;
        stall = 1'b1;
        flush = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag(arvalid, 1'b0, "arvalid under stall");
        end
    endtask

    task automatic do_flush(input addr_t fetch_pc);
        pc    = fetch_pc;
        stall = 1'b0;
        flush = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_inst(inst, `ICACHE_NOP, "inst under flush");
            check_flag(inst_valid, 1'b1, "inst_valid under flush");
            check_flag(arvalid, 1'b0, "arvalid under flush");
        end
        flush = 1'b0;
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        logic   pred_hit;
        e        = entries[i];
        pred_hit = model_hit(e.pc);
        if (e.kind != KIND_FLUSH && pred_hit !== e.exp_hit) begin
            failures++;
            $display("entry %0d: the table and the reference model disagree on hit for %h",
                     i, e.pc);
        end
        case (e.kind)
            KIND_FLUSH: do_flush(e.pc);
            KIND_STALL: begin
                hold_stall(e.pc);
                do_fetch(e.pc, pred_hit, `ICACHE_RESP_OKAY);
            end
            KIND_ERROR: do_fetch(e.pc, pred_hit, RESP_BAD);
            default:    do_fetch(e.pc, pred_hit, `ICACHE_RESP_OKAY);
        endcase
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        pc        = '0;
        flush     = 1'b0;
        // no miss may start right out of reset
        stall     = 1'b1;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rresp     = `ICACHE_RESP_OKAY;
        lfsr      = 32'h460b_73c2;
        exp_error = 1'b0;
        clear_model();
        load_entries();

        @(posedge clk);
        while (rst) @(posedge clk);
        @(negedge clk);
        check_flag(arvalid, 1'b0, "arvalid after reset");
        check_flag(rready, 1'b0, "rready after reset");
        check_flag(error, 1'b0, "error after reset");
        check_flag(inst_valid, 1'b1, "inst_valid after reset");
        check_inst(inst, `ICACHE_NOP, "inst after reset");

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("checks %0d, mismatches %0d, other errors %0d",
                     checks, mismatches, failures);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

/* ifu_icache.f */
+incdir+include
verilog/icache_pkg.sv
verilog/fetch_pkg.sv
verilog/icache_fill_if.sv
verilog/icache_tag_array.sv
verilog/icache_data_ram.sv
verilog/icache_miss_ctrl.sv
verilog/ifu_icache.sv
test/tb_clock_gen.sv
test/tb_ifu_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    -f ifu_icache.f \
    --top-module tb_ifu_icache \
    -o sim_ifu_icache

sim_out=$(./obj_dir/sim_ifu_icache)
echo "$sim_out"

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
